//--- project.f
logic/scope_pkg.sv
logic/key_state_tracker.sv
logic/raster_timebase.sv
logic/cursor_controller.sv
logic/trace_channel.sv
logic/pixel_compositor.sv
logic/scope_display_top.sv
+incdir+testbench
testbench/tb_scope_display.sv

//--- Makefile
VERILATOR   ?= verilator
TOP         ?= tb_scope_display
BUILD_DIR   ?= obj_dir
LOG         ?= sim.log
FILE_LIST   ?= project.f
VFLAGS      ?= --binary --assert -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILE_LIST)) testbench/scope_display_checks.svh
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: $(SIM_BIN)
	-$(SIM_BIN) | tee $(LOG)
	@if grep -q "Verification failed" $(LOG); then \
		echo "simulation FAILED"; exit 1; \
	elif ! grep -q "Verification passed" $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	else \
		echo "simulation PASSED"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- testbench/scope_display_checks.svh
`ifndef SCOPE_DISPLAY_CHECKS_SVH
`define SCOPE_DISPLAY_CHECKS_SVH

////////////////////////////////////////////////////////////
// random background source
////////////////////////////////////////////////////////////
function automatic logic [31:0] lfsr_next(input logic [31:0] state);
   logic fb;
   fb = state[31] ^ state[21] ^ state[1] ^ state[0];   // taps 32 22 2 1
   return {state[30:0], fb};
endfunction

////////////////////////////////////////////////////////////
// reference pixel model
////////////////////////////////////////////////////////////
// signed amplitude moved to offset binary, top 8 bits kept
function automatic int plot_level(input scope_pkg::sample_word_u s);
   int v;
   v = int'(s.amplitude >>> 4) + 128;
   return v;
endfunction

function automatic int trace_row(input int ch, input int level);
   return int'(scope_pkg::TRACE_TOP_Y[ch]) + (255 - level) / 2;
endfunction

function automatic logic in_cursor_square(input int x, input int y, input int cx, input int cy);
   return x >= cx && x < cx + scope_pkg::CURSOR_SIZE
          && y >= cy && y < cy + scope_pkg::CURSOR_SIZE;
endfunction

function automatic scope_pkg::rgb_t cursor_rgb(input logic [11:0] c);
   scope_pkg::rgb_t px;
   px.r = {c[11:8], 4'h0};   // 4 bit fields padded low
   px.g = {c[7:4], 4'h0};
   px.b = {c[3:0], 4'h0};
   return px;
endfunction

// one pixel step per arrow, never off screen
function automatic int step_axis(input int v, input logic dec, input logic inc, input int max);
   int n;
   n = v;
   if (dec && v > 0)
      n = n - 1;
   if (inc && v < max)
      n = n + 1;
   return n;
endfunction

`endif

//--- testbench/tb_scope_display.sv
`timescale 1ns/1ps

module tb_scope_display;

   localparam int FRAME_CYCLES = scope_pkg::SCREEN_W * scope_pkg::SCREEN_H;
   localparam int CLK_HALF_NS  = 20;
   localparam int RESET_CYCLES = 16;
   localparam int LEAD_CYCLES  = 1000;       // keeps key strobes away from frame start
   localparam int NUM_STEPS    = 21;

   typedef struct packed {
      logic [7:0]  key;
      logic        scroll;
      logic [11:0] sample_0;
      logic [11:0] sample_1;
      int          frames;
      logic [16:0] exp_keys;
   } step_t;

   // key byte, scroll, samples, frames to run, held keys after the strobe
   step_t steps [NUM_STEPS] = '{
      '{8'h00, 1'b0, 12'h000, 12'h000, 1, 17'h00000},   // reset picture
      '{8'h02, 1'b0, 12'h000, 12'h000, 0, 17'h10000},   // 1 down
      '{8'h77, 1'b0, 12'h000, 12'h000, 0, 17'h10000},   // unknown
      '{8'h3b, 1'b0, 12'h000, 12'h000, 0, 17'h10100},   // f1 down
      '{8'h82, 1'b0, 12'h000, 12'h000, 0, 17'h00100},   // 1 up
      '{8'hbb, 1'b0, 12'h000, 12'h000, 0, 17'h00000},   // f1 up
      '{8'hff, 1'b0, 12'h000, 12'h000, 0, 17'h00000},
      '{8'h00, 1'b1, 12'h305, 12'ha00, 1, 17'h00000},   // traces fill
      '{8'h00, 1'b0, 12'h7ff, 12'h800, 1, 17'h00000},   // frozen
      '{8'h4d, 1'b0, 12'h7ff, 12'h800, 0, 17'h00004},   // right
      '{8'h50, 1'b0, 12'h7ff, 12'h800, 4, 17'h00005},   // plus down
      '{8'hcd, 1'b0, 12'h7ff, 12'h800, 0, 17'h00001},
      '{8'hd0, 1'b0, 12'h7ff, 12'h800, 0, 17'h00000},
      '{8'h32, 1'b0, 12'h7ff, 12'h800, 0, 17'h00020},   // m, slow mode
      '{8'h4d, 1'b0, 12'h7ff, 12'h800, 0, 17'h00024},
      '{8'h50, 1'b0, 12'h7ff, 12'h800, 4, 17'h00025},
      '{8'hcd, 1'b0, 12'h7ff, 12'h800, 0, 17'h00021},
      '{8'hd0, 1'b0, 12'h7ff, 12'h800, 0, 17'h00020},
      '{8'hb2, 1'b0, 12'h7ff, 12'h800, 0, 17'h00000},
      '{8'h39, 1'b0, 12'h7ff, 12'h800, 0, 17'h00010},   // space toggles colour
      '{8'hb9, 1'b0, 12'h7ff, 12'h800, 1, 17'h00000}    // cursor over trace row 305
   };

   logic                                                 CLK_25MHZ;
   logic                                                 reset_from_key;
   logic [7:0]                                           key_event;
   logic                                                 key_event_ready;
   logic                                                 pixel_valid;
   scope_pkg::rgb_t                                      bg_rgb;
   scope_pkg::sample_word_u [scope_pkg::TRACE_COUNT-1:0] trace_samples;
   logic                                                 scroll_enable;
   scope_pkg::rgb_t                                      rgb_out;
   logic                                                 rgb_valid;
   scope_pkg::held_keys_t                                held_keys;
   scope_pkg::screen_pos_t                               cursor_pos;

   logic [31:0]     lfsr_state;
   logic [7:0]      level_hist [scope_pkg::TRACE_COUNT][scope_pkg::TRACE_W];
   int              hist_newest;
   int              hist_fill;
   int              cycle_cnt;                 // negedges since reset release
   int              pix_x;
   int              pix_y;
   int              frame_cnt;
   logic [16:0]     model_keys;
   int              model_cx;
   int              model_cy;
   logic            model_color;
   scope_pkg::rgb_t exp_pipe [3];
   logic            exp_valid [3];
   logic            step_scroll;
   logic [11:0]     step_sample [2];

`include "scope_display_checks.svh"

   initial CLK_25MHZ = 1'b0;
   always #CLK_HALF_NS CLK_25MHZ = ~CLK_25MHZ;

   scope_display_top i_dut
   (
      .CLK_25MHZ       (CLK_25MHZ),
      .reset_from_key  (reset_from_key),
      .key_event       (key_event),
      .key_event_ready (key_event_ready),
      .pixel_valid     (pixel_valid),
      .bg_rgb          (bg_rgb),
      .trace_samples   (trace_samples),
      .scroll_enable   (scroll_enable),
      .rgb_out         (rgb_out),
      .rgb_valid       (rgb_valid),
      .held_keys       (held_keys),
      .cursor_pos      (cursor_pos)
   );

   task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
      if (got !== exp)
      begin
         $display("[ERROR] time %0t signal %s got %0h expected %0h", $time, name, got, exp);
         $display("Verification failed");
         $fatal(1);
      end
   endtask

   task automatic draw_background(output scope_pkg::rgb_t bg);
      logic [23:0] bits;
      for (int i = 0; i < 24; i++)
      begin
         lfsr_state = lfsr_next(lfsr_state);
         bits[i]    = lfsr_state[0];
      end
      bg = bits;
   endtask

   ////////////////////////////////////////////////////////////
   // model of the pixel accepted on the coming edge
   ////////////////////////////////////////////////////////////
   task automatic model_pixel(input scope_pkg::rgb_t bg);
      int              edge_no;
      int              age;
      int              idx;
      logic            hit;
      scope_pkg::rgb_t px;
      edge_no = cycle_cnt + 1;   // coming edge is number edge_no + 1 after reset release
      // tick fills every 64th cycle after reset, the write lands on the edge after it
      if (step_scroll && edge_no % scope_pkg::SAMPLE_PERIOD_CYCLES == 0)
      begin
         hist_newest = (hist_newest + 1) % scope_pkg::TRACE_W;
         for (int ch = 0; ch < scope_pkg::TRACE_COUNT; ch++)
            level_hist[ch][hist_newest] = 8'(plot_level(step_sample[ch]));
         if (hist_fill < scope_pkg::TRACE_W)
            hist_fill++;
      end
      if (pix_x == 0 && pix_y == 0)
      begin
         if (!model_keys[5] || frame_cnt % scope_pkg::SLOW_FRAME_DIV == 0)
         begin
            model_cx = step_axis(model_cx, model_keys[3], model_keys[2],
                                 scope_pkg::SCREEN_W - scope_pkg::CURSOR_SIZE);
            model_cy = step_axis(model_cy, model_keys[1], model_keys[0],
                                 scope_pkg::SCREEN_H - scope_pkg::CURSOR_SIZE);
         end
         frame_cnt++;
      end
      hit = 1'b0;
      age = scope_pkg::TRACE_W - 1 - pix_x;                // newest sample sits at the right
      if (pix_x < scope_pkg::TRACE_W && age < hist_fill)
      begin
         idx = (hist_newest - age + scope_pkg::TRACE_W) % scope_pkg::TRACE_W;
         for (int ch = 0; ch < scope_pkg::TRACE_COUNT; ch++)
            if (pix_y == trace_row(ch, int'(level_hist[ch][idx])))
               hit = 1'b1;
      end
      if (in_cursor_square(pix_x, pix_y, model_cx, model_cy))
         px = cursor_rgb(scope_pkg::CURSOR_COLORS[model_color]);
      else if (hit)
         px = scope_pkg::TRACE_COLOR;
      else
         px = bg;
      exp_pipe[0]  = px;
      exp_valid[0] = 1'b1;
      pix_x++;
      if (pix_x == scope_pkg::SCREEN_W)
      begin
         pix_x = 0;
         pix_y = (pix_y + 1) % scope_pkg::SCREEN_H;
      end
   endtask

   task automatic drive_cycle(input logic [7:0] ev, input logic ready, input logic [16:0] keys);
      scope_pkg::rgb_t bg;
      @(negedge CLK_25MHZ);
      check_value("rgb_valid", rgb_valid, exp_valid[2]);
      if (exp_valid[2])
         check_value("rgb_out", rgb_out, exp_pipe[2]);
      exp_pipe[2]  = exp_pipe[1];
      exp_valid[2] = exp_valid[1];
      exp_pipe[1]  = exp_pipe[0];
      exp_valid[1] = exp_valid[0];
      draw_background(bg);
      key_event        = ready ? ev : 8'h00;
      key_event_ready  = ready;
      pixel_valid      = 1'b1;
      bg_rgb           = bg;
      scroll_enable    = step_scroll;
      trace_samples[0] = step_sample[0];
      trace_samples[1] = step_sample[1];
      if (ready)
      begin
         if (keys[4] && !model_keys[4])   // space press
            model_color = !model_color;
         model_keys = keys;
      end
      model_pixel(bg);
      cycle_cnt++;
   endtask

   initial
   begin
      longint total_frames;
      total_frames = 0;
      for (int s = 0; s < NUM_STEPS; s++)
         total_frames += steps[s].frames;
      #(2 * total_frames * FRAME_CYCLES * 2 * CLK_HALF_NS);
      $display("run timed out before all steps finished");
      $display("Verification failed");
      $fatal(1);
   end

   initial
   begin
      reset_from_key  = 1'b1;
      key_event       = 8'h00;
      key_event_ready = 1'b0;
      pixel_valid     = 1'b0;
      bg_rgb          = '0;
      trace_samples   = '0;
      scroll_enable   = 1'b0;
      lfsr_state      = 32'h8c12;
      hist_newest     = scope_pkg::TRACE_W - 1;
      hist_fill       = 0;
      cycle_cnt       = 0;
      pix_x           = 0;
      pix_y           = 0;
      frame_cnt       = 0;
      model_keys      = '0;
      model_cx        = int'(scope_pkg::CURSOR_HOME_X);
      model_cy        = int'(scope_pkg::CURSOR_HOME_Y);
      model_color     = 1'b0;
      step_scroll     = 1'b0;
      step_sample[0]  = '0;
      step_sample[1]  = '0;
      for (int i = 0; i < 3; i++)
      begin
         exp_pipe[i]  = '0;
         exp_valid[i] = 1'b0;
      end
      repeat (RESET_CYCLES) @(posedge CLK_25MHZ);
      @(negedge CLK_25MHZ);
      reset_from_key = 1'b0;
      check_value("held_keys", held_keys, 17'h0);
      check_value("cursor_pos", cursor_pos,
                  {scope_pkg::CURSOR_HOME_X, scope_pkg::CURSOR_HOME_Y});
      repeat (LEAD_CYCLES) drive_cycle(8'h00, 1'b0, model_keys);

      for (int s = 0; s < NUM_STEPS; s++)
      begin
         step_scroll    = steps[s].scroll;
         step_sample[0] = steps[s].sample_0;
         step_sample[1] = steps[s].sample_1;
         drive_cycle(steps[s].key, 1'b1, steps[s].exp_keys);
         drive_cycle(8'h00, 1'b0, model_keys);
         check_value("held_keys", held_keys, steps[s].exp_keys);
         repeat (steps[s].frames * FRAME_CYCLES) drive_cycle(8'h00, 1'b0, model_keys);
         check_value("cursor_pos", cursor_pos, {11'(model_cx), 11'(model_cy)});
      end

      // 4 full frames, then 4 slow frames with one move
      check_value("cursor_pos", cursor_pos, {11'd401, 11'd301});
      $display("Verification passed");
      $finish;
   end

endmodule

//--- logic/scope_display_top.sv
`timescale 1ns/1ps

module scope_display_top
(
   input  logic                                                CLK_25MHZ,
   input  logic                                                reset_from_key,
   input  logic [7:0]                                          key_event,
   input  logic                                                key_event_ready,
   input  logic                                                pixel_valid,
   input  scope_pkg::rgb_t                                     bg_rgb,
   input  scope_pkg::sample_word_u [scope_pkg::TRACE_COUNT-1:0] trace_samples,
   input  logic                                                scroll_enable,
   output scope_pkg::rgb_t                                     rgb_out,
   output logic                                                rgb_valid,
   output scope_pkg::held_keys_t                               held_keys,
   output scope_pkg::screen_pos_t                              cursor_pos
);

   scope_pkg::raster_t                raster;       // stage 1 position
   logic                              frame_start;
   logic                              sample_tick;
   logic [11:0]                       cursor_color;
   logic [scope_pkg::TRACE_COUNT-1:0] trace_hit;

   key_state_tracker i_key_state_tracker
   (
      .CLK_25MHZ       (CLK_25MHZ),
      .reset_from_key  (reset_from_key),
      .key_event       (key_event),
      .key_event_ready (key_event_ready),
      .held_keys       (held_keys)
   );

   raster_timebase i_raster_timebase
   (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .pixel_valid    (pixel_valid),
      .raster         (raster),
      .frame_start    (frame_start),
      .sample_tick    (sample_tick)
   );

   cursor_controller i_cursor_controller
   (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .frame_start    (frame_start),
      .held_keys      (held_keys),
      .cursor_pos     (cursor_pos),
      .cursor_color   (cursor_color)
   );

   ////////////////////////////////////////////////////////////
   // one scrolling trace per dds sample word
   ////////////////////////////////////////////////////////////
   for (genvar k = 0; k < scope_pkg::TRACE_COUNT; k++)
   begin : g_trace
      trace_channel
      #(
         .CHANNEL (k)
      )
      i_trace_channel
      (
         .CLK_25MHZ      (CLK_25MHZ),
         .reset_from_key (reset_from_key),
         .sample         (trace_samples[k]),
         .scroll_enable  (scroll_enable),
         .sample_tick    (sample_tick),
         .raster         (raster),
         .trace_hit      (trace_hit[k])
      );
   end

   pixel_compositor i_pixel_compositor
   (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .raster         (raster),
      .bg_rgb         (bg_rgb),
      .trace_hit      (trace_hit),
      .cursor_pos     (cursor_pos),
      .cursor_color   (cursor_color),
      .rgb_out        (rgb_out),
      .rgb_valid      (rgb_valid)
   );

endmodule

//--- logic/pixel_compositor.sv
`timescale 1ns/1ps

module pixel_compositor
(
   input  logic                              CLK_25MHZ,
   input  logic                              reset_from_key,
   input  scope_pkg::raster_t                raster,
   input  scope_pkg::rgb_t                   bg_rgb,
   input  logic [scope_pkg::TRACE_COUNT-1:0] trace_hit,
   input  scope_pkg::screen_pos_t            cursor_pos,
   input  logic [11:0]                       cursor_color,
   output scope_pkg::rgb_t                   rgb_out,
   output logic                              rgb_valid
);

   logic                   valid_s2;
   scope_pkg::screen_pos_t pos_s2;
   scope_pkg::rgb_t        bg_s1;      // background arrives with pixel_valid
   scope_pkg::rgb_t        bg_s2;
   scope_pkg::rgb_t        cursor_rgb;
   scope_pkg::rgb_t        pixel_rgb;
   logic                   in_cursor;

   assign cursor_rgb = '{r: {cursor_color[11:8], 4'h0},
                         g: {cursor_color[7:4], 4'h0},
                         b: {cursor_color[3:0], 4'h0}};

   assign in_cursor = pos_s2.x >= cursor_pos.x && pos_s2.x < cursor_pos.x + scope_pkg::CURSOR_SIZE
                      && pos_s2.y >= cursor_pos.y
                      && pos_s2.y < cursor_pos.y + scope_pkg::CURSOR_SIZE;

   ////////////////////////////////////////////////////////////
   // priority mux, cursor over traces over background
   ////////////////////////////////////////////////////////////
   always_comb
   begin
      if (in_cursor)
         pixel_rgb = cursor_rgb;
      else if (|trace_hit)
         pixel_rgb = scope_pkg::TRACE_COLOR;
      else
         pixel_rgb = bg_s2;
   end

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         valid_s2  <= 1'b0;
         rgb_valid <= 1'b0;
      end
      else
      begin
         valid_s2  <= raster.valid;
         rgb_valid <= valid_s2;                 // stage 3
      end
   end

   always_ff @(posedge CLK_25MHZ)
   begin
      bg_s1   <= bg_rgb;
      bg_s2   <= bg_s1;
      pos_s2  <= raster.pos;
      rgb_out <= pixel_rgb;
   end

   // channels register their hit in step with this stage
   a_hit_in_stage_2 : assert property (@(posedge CLK_25MHZ) disable iff (reset_from_key)
      |trace_hit |-> valid_s2);

endmodule

//--- logic/trace_channel.sv
`timescale 1ns/1ps

module trace_channel
#(
   parameter int CHANNEL = 0
)
(
   input  logic                    CLK_25MHZ,
   input  logic                    reset_from_key,
   input  scope_pkg::sample_word_u sample,
   input  logic                    scroll_enable,
   input  logic                    sample_tick,
   input  scope_pkg::raster_t      raster,
   output logic                    trace_hit
);

   logic [scope_pkg::PLOT_W-1:0]      level_mem [scope_pkg::TRACE_W];
   logic [scope_pkg::TRACE_PTR_W-1:0] wr_ptr;
   logic [scope_pkg::TRACE_PTR_W:0]   fill_cnt;    // samples held, stops at TRACE_W
   logic [scope_pkg::PLOT_W-1:0]      wr_level;
   logic                              write_now;
   logic [scope_pkg::COORD_W-1:0]     rd_sum;
   logic [scope_pkg::TRACE_PTR_W-1:0] rd_addr;
   logic [scope_pkg::PLOT_W-1:0]      rd_level;
   logic [scope_pkg::PLOT_W-2:0]      plot_row;
   logic [scope_pkg::COORD_W-1:0]     plot_y;
   logic                              in_trace;

   assign wr_level  = {~sample.fields.sign, sample.fields.upper};  // signed to offset binary
   assign write_now = sample_tick && scroll_enable;

   ////////////////////////////////////////////////////////////
   // sample capture
   ////////////////////////////////////////////////////////////
   always_ff @(posedge CLK_25MHZ)
   begin
      if (write_now)
         level_mem[wr_ptr] <= wr_level;
   end

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         wr_ptr   <= '0;
         fill_cnt <= '0;
      end
      else if (write_now)
      begin
         wr_ptr <= (wr_ptr == scope_pkg::TRACE_W - 1) ? '0 : wr_ptr + 1'b1;
         if (fill_cnt != scope_pkg::TRACE_W)
            fill_cnt <= fill_cnt + 1'b1;
      end
   end

   ////////////////////////////////////////////////////////////
   // hit test, column x holds the sample from TRACE_W - x ticks back
   ////////////////////////////////////////////////////////////
   assign rd_sum   = raster.pos.x + scope_pkg::COORD_W'(wr_ptr);
   assign rd_addr  = scope_pkg::TRACE_PTR_W'((rd_sum >= scope_pkg::TRACE_W) ?
                                             rd_sum - scope_pkg::TRACE_W : rd_sum);
   assign rd_level = level_mem[rd_addr];
   assign plot_row = ~rd_level[scope_pkg::PLOT_W-1:1];            // (255 - level) / 2
   assign plot_y   = scope_pkg::TRACE_TOP_Y[CHANNEL] + scope_pkg::COORD_W'(plot_row);
   assign in_trace = raster.valid && raster.pos.x < scope_pkg::TRACE_W
                     && raster.pos.x + fill_cnt >= scope_pkg::TRACE_W;  // unwritten columns stay dark

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
         trace_hit <= 1'b0;
      else
         trace_hit <= in_trace && raster.pos.y == plot_y;   // lines up with stage 2
   end

   a_wr_ptr_range : assert property (@(posedge CLK_25MHZ) disable iff (reset_from_key)
      wr_ptr < scope_pkg::TRACE_W);

endmodule

//--- logic/cursor_controller.sv
`timescale 1ns/1ps

module cursor_controller
(
   input  logic                   CLK_25MHZ,
   input  logic                   reset_from_key,
   input  logic                   frame_start,
   input  scope_pkg::held_keys_t  held_keys,
   output scope_pkg::screen_pos_t cursor_pos,
   output logic [11:0]            cursor_color
);

   logic [scope_pkg::COORD_W-1:0]    pos_x;
   logic [scope_pkg::COORD_W-1:0]    pos_y;
   logic [scope_pkg::COORD_W-1:0]    next_x;
   logic [scope_pkg::COORD_W-1:0]    next_y;
   logic [scope_pkg::SLOW_CNT_W-1:0] slow_cnt;     // frame phase for slow mode
   logic                             move_ok;
   logic                             space_q;
   logic                             color_idx;

   assign move_ok = !held_keys.m || slow_cnt == '0;  // M held, one frame in four

   ////////////////////////////////////////////////////////////
   // one pixel step per held arrow, clamped to the screen
   ////////////////////////////////////////////////////////////
   always_comb
   begin
      next_x = pos_x;
      next_y = pos_y;
      if (held_keys.left && pos_x != '0)
         next_x = next_x - 1'b1;
      if (held_keys.right && pos_x < scope_pkg::CURSOR_MAX_X)
         next_x = next_x + 1'b1;
      if (held_keys.up && pos_y != '0)
         next_y = next_y - 1'b1;
      if (held_keys.down && pos_y < scope_pkg::CURSOR_MAX_Y)
         next_y = next_y + 1'b1;
   end

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         pos_x    <= scope_pkg::CURSOR_HOME_X;
         pos_y    <= scope_pkg::CURSOR_HOME_Y;
         slow_cnt <= '0;
      end
      else if (frame_start)
      begin
         slow_cnt <= (slow_cnt == scope_pkg::SLOW_FRAME_DIV - 1) ? '0 : slow_cnt + 1'b1;
         if (move_ok)
         begin
            pos_x <= next_x;
            pos_y <= next_y;
         end
      end
   end

   // space press flips the colour, holding it does nothing more
   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         space_q   <= 1'b0;
         color_idx <= 1'b0;
      end
      else
      begin
         space_q <= held_keys.space;
         if (held_keys.space && !space_q)
            color_idx <= !color_idx;
      end
   end

   assign cursor_pos   = '{x: pos_x, y: pos_y};
   assign cursor_color = scope_pkg::CURSOR_COLORS[color_idx];

   a_cursor_in_bounds : assert property (@(posedge CLK_25MHZ) disable iff (reset_from_key)
      pos_x <= scope_pkg::CURSOR_MAX_X && pos_y <= scope_pkg::CURSOR_MAX_Y);

endmodule

//--- logic/raster_timebase.sv
`timescale 1ns/1ps

module raster_timebase
(
   input  logic               CLK_25MHZ,
   input  logic               reset_from_key,
   input  logic               pixel_valid,
   output scope_pkg::raster_t raster,
   output logic               frame_start,
   output logic               sample_tick
);

   logic [scope_pkg::COORD_W-1:0]      x_cnt;
   logic [scope_pkg::COORD_W-1:0]      y_cnt;
   logic [scope_pkg::SAMPLE_CNT_W-1:0] tick_cnt;
   logic                               last_x;
   logic                               last_y;
   logic                               raster_valid;
   scope_pkg::screen_pos_t             raster_pos;

   assign last_x = x_cnt == scope_pkg::SCREEN_W - 1;
   assign last_y = y_cnt == scope_pkg::SCREEN_H - 1;

   // position of the next accepted pixel
   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         x_cnt <= '0;
         y_cnt <= '0;
      end
      else if (pixel_valid)
      begin
         if (last_x)
         begin
            x_cnt <= '0;
            y_cnt <= last_y ? '0 : y_cnt + 1'b1;
         end
         else
         begin
            x_cnt <= x_cnt + 1'b1;
         end
      end
   end

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         raster_valid <= 1'b0;
         frame_start  <= 1'b0;
         tick_cnt     <= '0;
         sample_tick  <= 1'b0;
      end
      else
      begin
         raster_valid <= pixel_valid;
         frame_start  <= pixel_valid && x_cnt == '0 && y_cnt == '0;  // lines up with stage 1
         tick_cnt     <= (tick_cnt == scope_pkg::SAMPLE_PERIOD_CYCLES - 1) ? '0
                                                                           : tick_cnt + 1'b1;
         sample_tick  <= tick_cnt == scope_pkg::SAMPLE_PERIOD_CYCLES - 1;  // free running
      end
   end

   always_ff @(posedge CLK_25MHZ)
   begin
      raster_pos <= '{x: x_cnt, y: y_cnt};   // stage 1
   end

   assign raster = '{valid: raster_valid, pos: raster_pos};

   a_raster_on_screen : assert property (@(posedge CLK_25MHZ) disable iff (reset_from_key)
      raster.valid |-> raster.pos.x < scope_pkg::SCREEN_W && raster.pos.y < scope_pkg::SCREEN_H);

endmodule

//--- logic/key_state_tracker.sv
`timescale 1ns/1ps

module key_state_tracker
(
   input  logic                  CLK_25MHZ,
   input  logic                  reset_from_key,
   input  logic [7:0]            key_event,
   input  logic                  key_event_ready,
   output scope_pkg::held_keys_t held_keys
);

   logic [scope_pkg::KEY_COUNT-1:0] key_flags;   // bit k follows KEY_MAKE_CODES[k]
   logic [scope_pkg::KEY_COUNT-1:0] make_hit;
   logic [scope_pkg::KEY_COUNT-1:0] break_hit;

   ////////////////////////////////////////////////////////////
   // event byte decode
   ////////////////////////////////////////////////////////////
   always_comb
   begin
      for (int k = 0; k < scope_pkg::KEY_COUNT; k++)
      begin
         make_hit[k]  = key_event == scope_pkg::KEY_MAKE_CODES[k];
         break_hit[k] = key_event == scope_pkg::KEY_MAKE_CODES[k]
                                     + scope_pkg::KEY_BREAK_OFFSET;  // break is make + 128
      end
   end

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         key_flags <= '0;
      end
      else if (key_event_ready)
      begin
         key_flags <= (key_flags | make_hit) & ~break_hit;  // unknown byte hits nothing
      end
   end

   assign held_keys = scope_pkg::held_keys_t'(key_flags);

endmodule

//--- logic/scope_pkg.sv
package scope_pkg;

   ////////////////////////////////////////////////////////////
   // screen and trace geometry
   ////////////////////////////////////////////////////////////
   localparam int SCREEN_W = 800;
   localparam int SCREEN_H = 600;
   localparam int COORD_W = 11;
   localparam int TRACE_COUNT = 2;
   localparam int TRACE_W = 640;                      // columns from x = 0
   localparam int TRACE_PTR_W = $clog2(TRACE_W);
   localparam int PLOT_W = 8;                         // offset binary plot level
   localparam logic [TRACE_COUNT-1:0][COORD_W-1:0] TRACE_TOP_Y = {11'd438, 11'd266};
   localparam int SAMPLE_PERIOD_CYCLES = 64;
   localparam int SAMPLE_CNT_W = $clog2(SAMPLE_PERIOD_CYCLES);

   ////////////////////////////////////////////////////////////
   // cursor
   ////////////////////////////////////////////////////////////
   localparam int CURSOR_SIZE = 8;
   localparam logic [COORD_W-1:0] CURSOR_HOME_X = 11'd396;
   localparam logic [COORD_W-1:0] CURSOR_HOME_Y = 11'd296;
   localparam logic [COORD_W-1:0] CURSOR_MAX_X = COORD_W'(SCREEN_W - CURSOR_SIZE);
   localparam logic [COORD_W-1:0] CURSOR_MAX_Y = COORD_W'(SCREEN_H - CURSOR_SIZE);
   localparam logic [1:0][11:0] CURSOR_COLORS = {12'hf00, 12'hfff};  // [0] white, [1] red
   localparam int SLOW_FRAME_DIV = 4;
   localparam int SLOW_CNT_W = $clog2(SLOW_FRAME_DIV);

   ////////////////////////////////////////////////////////////
   // keyboard
   ////////////////////////////////////////////////////////////
   localparam int KEY_COUNT = 17;
   localparam logic [7:0] KEY_BREAK_OFFSET = 8'd128;

   // listed msb first, so entry k lines up with bit k of held_keys_t
   localparam logic [KEY_COUNT-1:0][7:0] KEY_MAKE_CODES = {
      8'h02, 8'h03, 8'h04, 8'h05, 8'h06, 8'h07, 8'h08, 8'h09,  // 1 to 8
      8'h3b, 8'h3c,                                            // f1 f2
      8'h31, 8'h32, 8'h39,                                     // n m space
      8'h4b, 8'h4d, 8'h48, 8'h50                               // left right up down
   };

   typedef struct packed {
      logic [7:0] r;
      logic [7:0] g;
      logic [7:0] b;
   } rgb_t;

   typedef struct packed {
      logic [COORD_W-1:0] x;
      logic [COORD_W-1:0] y;
   } screen_pos_t;

   typedef struct packed {
      logic key_1;
      logic key_2;
      logic key_3;
      logic key_4;
      logic key_5;
      logic key_6;
      logic key_7;
      logic key_8;
      logic f1;
      logic f2;
      logic n;
      logic m;              // slow cursor
      logic space;          // colour toggle
      logic left;
      logic right;
      logic up;
      logic down;
   } held_keys_t;

   typedef struct packed {
      logic       sign;
      logic [6:0] upper;    // plotted bits
      logic [3:0] low;
   } sample_fields_t;

   // one dds word, read as a number or as plot fields
   typedef union packed {
      logic signed [11:0] amplitude;
      sample_fields_t     fields;
   } sample_word_u;

   typedef struct packed {
      logic        valid;
      screen_pos_t pos;
   } raster_t;

   localparam rgb_t TRACE_COLOR = '{r: 8'h00, g: 8'hff, b: 8'h30};

endpackage
